// File: Makefile
TOP := tb_ucode

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --top-module $(TOP) -f flist.f

sim:
	verilator --binary --timing --top-module $(TOP) -f flist.f -o $(TOP)
	@out="$$(./obj_dir/$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation finished: PASS"

clean:
	rm -rf obj_dir

// File: common/ucode_pkg.sv
package ucode_pkg;

localparam int UADDR_W = 8;
localparam int UWORD_W = 18;

typedef logic [UADDR_W-1:0] ucode_addr_t;

typedef enum logic [1:0] {
        MCTYPE0 = 2'd0, // Data transfer
        MCTYPE1 = 2'd1, // Address calculation
        MCTYPE2 = 2'd2, // Special operation
        MCTYPE3 = 2'd3  // Sequence control
} mc_kind_t;

// RD4 also fetches the next opcode
typedef enum logic [1:0] {IDLE = 2'd0, RD3 = 2'd1, WR3 = 2'd2, RD4 = 2'd3} bus_cycle_t;

typedef enum logic [3:0] {
        T0S_IGNORE, T0S_A, T0S_R1, T0S_R, T0S_R2, T0S_SRTMP, T0S_MD0, T0S_MD, T0S_PSW
} t0_src_t;

typedef enum logic [3:0] {
        T0D_IGNORE, T0D_A, T0D_R1, T0D_R, T0D_R2, T0D_SRTMP, T0D_MD0, T0D_MD, T0D_PSW
} t0_dst_t;

typedef enum logic [3:0] {DEU_MOV, DEU_COMOP, DEU_INC, DEU_DEC} t0_deu_t;

typedef enum logic [3:0] {
        T1S_IGNORE, T1S_AAUX, T1S_RPA, T1S_RPA2, T1S_RPA_OFFSET,
        T1S_BC, T1S_SP, T1S_PC, T1S_A_REL_S, T1S_A_REL_L
} t1_src_t;

typedef enum logic [3:0] {T1D_MA, T1D_PC, T1D_MD} t1_dst_t;

typedef enum logic [3:0] {AEU_MOV, AEU_ADD, AEU_RPA_ADJ, AEU_PUSH, AEU_POP} t1_aeu_t;

typedef enum logic [3:0] {
        T2_NOP, T2_STA_SR, T2_STA_SR2, T2_STA_WORD, T2_STA_BYTE, T2_STA_IRO,
        T2_IRQ_MOD, T2_SUSP_EN
} t2_op_t;

typedef enum logic [3:0] {T3_BRA_ON_ALU, T3_IRD} t3_op_t;

typedef struct packed {
        t0_src_t    src;
        t0_dst_t    dst;
        t0_deu_t    op;
        bus_cycle_t bus;
} t0_body_t;

typedef struct packed {
        t1_src_t    src;
        t1_dst_t    dst;
        t1_aeu_t    op;
        bus_cycle_t bus;
} t1_body_t;

typedef struct packed {
        t2_op_t     op;
        logic [7:0] rsvd;
        bus_cycle_t bus;
} t2_body_t;

typedef struct packed {
        t3_op_t     op;
        logic [2:0] offset; // Branch distance
        logic [4:0] rsvd;
        bus_cycle_t bus;
} t3_body_t;

// Bus code sits in the same two bits for every kind
typedef union packed {
        t0_body_t t0;
        t1_body_t t1;
        t2_body_t t2;
        t3_body_t t3;
} ucode_body_u;

typedef struct packed {
        mc_kind_t    kind;
        logic        flag;  // Update flags
        logic        skip;  // Check skip
        ucode_body_u body;
} ucode_word_t;

localparam ucode_word_t NOP_WORD = ucode_word_t'({MCTYPE2, 1'b0, 1'b1, T2_NOP, 8'h00, RD4});

typedef struct packed {
        t0_src_t src;
        t0_dst_t dst;
        t0_deu_t op;
} t0_ctrl_t;

typedef struct packed {
        t1_src_t src;
        t1_dst_t dst;
        t1_aeu_t op;
} t1_ctrl_t;

typedef struct packed {
        t3_op_t     op;
        logic [2:0] offset;
} t3_ctrl_t;

typedef struct packed {
        mc_kind_t   kind;
        logic       flag;
        logic       skip;
        bus_cycle_t bus;
        t0_ctrl_t   t0;
        t1_ctrl_t   t1;
        t2_op_t     t2_op;
        t3_ctrl_t   t3;
        logic       bus_read;
        logic       bus_write;
        logic       last_step;
} ucode_ctrl_t;

// Entry addresses, multi-step entries leave room for their steps
localparam ucode_addr_t MOV_R1_A    = 8'h00;
localparam ucode_addr_t MOV_A_R1    = 8'h01;
localparam ucode_addr_t MOV_SR_A    = 8'h02;
localparam ucode_addr_t MOV_A_SR1   = 8'h05;
localparam ucode_addr_t MOV_R_MEM   = 8'h08;
localparam ucode_addr_t MOV_MEM_R   = 8'h0c;
localparam ucode_addr_t MVI_R_IM    = 8'h10;
localparam ucode_addr_t LDAW        = 8'h12;
localparam ucode_addr_t STAW        = 8'h15;
localparam ucode_addr_t LDAX_A_RPA  = 8'h18;
localparam ucode_addr_t LDAX_A_RPA2 = 8'h1a;
localparam ucode_addr_t STAX_RPA_A  = 8'h1e;
localparam ucode_addr_t STAX_RPA2_A = 8'h20;
localparam ucode_addr_t ALU_A_R     = 8'h24;
localparam ucode_addr_t ALU_R_A     = 8'h25;
localparam ucode_addr_t ALUI_A_IM   = 8'h26;
localparam ucode_addr_t ALUI_SR2_IM = 8'h28;
localparam ucode_addr_t JMP         = 8'h2d;
localparam ucode_addr_t JB          = 8'h30;
localparam ucode_addr_t JR          = 8'h31;
localparam ucode_addr_t CALL        = 8'h34;
localparam ucode_addr_t RET_RETS    = 8'h39;
localparam ucode_addr_t EIDI        = 8'h3c;
localparam ucode_addr_t SUSP        = 8'h3d;
localparam ucode_addr_t NOP         = 8'h3e;
localparam ucode_addr_t IRD         = 8'h3f;

// Word builders, fs is {flag, skip}
function automatic ucode_word_t t0w(logic [1:0] fs, t0_src_t s, t0_dst_t d, t0_deu_t op,
                                    bus_cycle_t bus);
        return ucode_word_t'({MCTYPE0, fs, s, d, op, bus});
endfunction

function automatic ucode_word_t t1w(logic [1:0] fs, t1_src_t s, t1_dst_t d, t1_aeu_t op,
                                    bus_cycle_t bus);
        return ucode_word_t'({MCTYPE1, fs, s, d, op, bus});
endfunction

function automatic ucode_word_t t2w(logic [1:0] fs, t2_op_t op, bus_cycle_t bus);
        return ucode_word_t'({MCTYPE2, fs, op, 8'h00, bus});
endfunction

function automatic ucode_word_t t3w(logic [1:0] fs, t3_op_t op, logic [2:0] ofs,
                                    bus_cycle_t bus);
        return ucode_word_t'({MCTYPE3, fs, op, ofs, 5'h00, bus});
endfunction

endpackage

// File: flist.f
common/ucode_pkg.sv
ucode/ucode_rom.sv
ucode/ucode_decoder.sv
ucode/ucode_top.sv
tests/tb_ucode.sv

// File: tests/tb_ucode.sv
`timescale 1ns/1ps

module tb_ucode;

localparam int MAX_VECS   = 128;
localparam int RAND_READS = 8;
localparam int NUM_COLS   = 19;

logic                   i_CLK;
logic                   arst_n;
logic                   read_tick;
ucode_pkg::ucode_addr_t ucode_addr;
ucode_pkg::ucode_word_t ucode_word;
ucode_pkg::ucode_ctrl_t ctrl;
logic                   ctrl_valid;

ucode_pkg::ucode_addr_t vec_addr [MAX_VECS];
logic                   vec_tick [MAX_VECS];
ucode_pkg::ucode_word_t vec_word [MAX_VECS];
ucode_pkg::ucode_ctrl_t vec_ctrl [MAX_VECS];
logic                   mapped   [256]; // Addresses that hold a table entry
int                     num_vecs;
int                     errors;
int                     checks;
int                     seed;
logic                   loaded;

ucode_top dut0 (
        .i_CLK      (i_CLK),
        .arst_n     (arst_n),
        .read_tick  (read_tick),
        .ucode_addr (ucode_addr),
        .ucode_word (ucode_word),
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid)
);

initial begin
        i_CLK = 1'b0;
        forever #5 i_CLK = ~i_CLK;
end

// Expected control built from the decoded columns of one data line
function automatic ucode_pkg::ucode_ctrl_t fields_to_ctrl(input logic [31:0] col [NUM_COLS]);
        ucode_pkg::ucode_ctrl_t c;

        c = '0;
        c.kind      = ucode_pkg::mc_kind_t'(col[3][1:0]);
        c.flag      = col[4][0];
        c.skip      = col[5][0];
        c.bus       = ucode_pkg::bus_cycle_t'(col[6][1:0]);
        c.t0.src    = ucode_pkg::t0_src_t'(col[7][3:0]);
        c.t0.dst    = ucode_pkg::t0_dst_t'(col[8][3:0]);
        c.t0.op     = ucode_pkg::t0_deu_t'(col[9][3:0]);
        c.t1.src    = ucode_pkg::t1_src_t'(col[10][3:0]);
        c.t1.dst    = ucode_pkg::t1_dst_t'(col[11][3:0]);
        c.t1.op     = ucode_pkg::t1_aeu_t'(col[12][3:0]);
        c.t2_op     = ucode_pkg::t2_op_t'(col[13][3:0]);
        c.t3.op     = ucode_pkg::t3_op_t'(col[14][3:0]);
        c.t3.offset = col[15][2:0];
        c.bus_read  = col[16][0];
        c.bus_write = col[17][0];
        c.last_step = col[18][0];
        return c;
endfunction

// Type 2 NOP with skip set, RD4 fetches the next opcode
function automatic ucode_pkg::ucode_ctrl_t nop_ctrl();
        ucode_pkg::ucode_ctrl_t c;

        c = '0;
        c.kind      = ucode_pkg::MCTYPE2;
        c.skip      = 1'b1;
        c.bus       = ucode_pkg::RD4;
        c.t2_op     = ucode_pkg::T2_NOP;
        c.bus_read  = 1'b1;
        c.last_step = 1'b1;
        return c;
endfunction

task automatic check_word(input ucode_pkg::ucode_word_t got, input ucode_pkg::ucode_word_t exp,
                          input string where);
        checks++;
        if (got !== exp) begin
                errors++;
                $display("[ERROR] ucode_word %s: got %h, expected %h", where, got, exp);
        end
endtask

task automatic check_ctrl(input ucode_pkg::ucode_ctrl_t got, input ucode_pkg::ucode_ctrl_t exp,
                          input string where);
        checks++;
        if (got !== exp) begin
                errors++;
                $display("[ERROR] ctrl %s: got %h, expected %h", where, got, exp);
        end
endtask

task automatic check_valid(input logic got, input logic exp, input string where);
        checks++;
        if (got !== exp) begin
                errors++;
                $display("[ERROR] ctrl_valid %s: got %h, expected %h", where, got, exp);
        end
endtask

task automatic load_vectors();
        int          fd;
        int          n;
        string       rest;
        logic [31:0] col [NUM_COLS];

        fd = $fopen("tests/ucode_testdata.txt", "r");
        if (fd == 0) begin
                errors++;
                $display("Could not open the test data file tests/ucode_testdata.txt");
        end else begin
                while (!$feof(fd) && num_vecs < MAX_VECS) begin
                        n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                                    col[0], col[1], col[2], col[3], col[4], col[5], col[6],
                                    col[7], col[8], col[9], col[10], col[11], col[12], col[13],
                                    col[14], col[15], col[16], col[17], col[18]);
                        if (n == NUM_COLS) begin
                                vec_addr[num_vecs] = col[0][7:0];
                                vec_tick[num_vecs] = col[1][0];
                                vec_word[num_vecs] = ucode_pkg::ucode_word_t'(col[2][17:0]);
                                vec_ctrl[num_vecs] = fields_to_ctrl(col);
                                if (col[1][0]) begin
                                        mapped[col[0][7:0]] = 1'b1;
                                end
                                num_vecs++;
                        end else begin
                                if (n > 0) begin
                                        errors++;
                                        $display("Malformed line in the test data file");
                                end
                                n = $fgets(rest, fd); // Skip comment or rest of line
                        end
                end
                $fclose(fd);
        end
endtask

// Random reads outside every table address
task automatic add_unmapped();
        logic [31:0]            r;
        ucode_pkg::ucode_addr_t a;

        repeat (RAND_READS) begin
                do begin
                        r = $random(seed);
                        a = r[7:0];
                end while (mapped[a]);
                if (num_vecs < MAX_VECS) begin
                        vec_addr[num_vecs] = a;
                        vec_tick[num_vecs] = 1'b1;
                        vec_word[num_vecs] = ucode_pkg::NOP_WORD;
                        vec_ctrl[num_vecs] = nop_ctrl();
                        num_vecs++;
                end
        end
endtask

initial begin
        int i;

        read_tick  = 1'b0;
        ucode_addr = '0;
        arst_n     = 1'b0;
        errors     = 0;
        checks     = 0;
        num_vecs   = 0;
        loaded     = 1'b0;
        seed       = 32'hefb29d72;
        for (i = 0; i < 256; i++) begin
                mapped[i] = 1'b0;
        end
        load_vectors();
        if (num_vecs == 0) begin
                errors++;
                $display("No test vectors were read from the data file");
        end
        add_unmapped();
        loaded = 1'b1;

        repeat (3) @(posedge i_CLK);
        @(negedge i_CLK);
        arst_n = 1'b1;
        @(negedge i_CLK);
        check_word(ucode_word, ucode_pkg::NOP_WORD, "after reset");
        check_ctrl(ctrl, nop_ctrl(), "after reset");
        check_valid(ctrl_valid, 1'b0, "after reset");

        // Word checked one cycle after its tick, ctrl one cycle later
        for (i = 0; i < num_vecs + 2; i++) begin
                @(negedge i_CLK);
                if (i >= 1 && i <= num_vecs) begin
                        check_word(ucode_word, vec_word[i-1],
                                   $sformatf("vector %0d addr %h", i - 1, vec_addr[i-1]));
                end
                if (i >= 2) begin
                        check_ctrl(ctrl, vec_ctrl[i-2],
                                   $sformatf("vector %0d addr %h", i - 2, vec_addr[i-2]));
                        check_valid(ctrl_valid, vec_tick[i-2],
                                    $sformatf("vector %0d addr %h", i - 2, vec_addr[i-2]));
                end
                if (i < num_vecs) begin
                        read_tick  = vec_tick[i];
                        ucode_addr = vec_addr[i];
                end else begin
                        read_tick  = 1'b0;
                        ucode_addr = '0;
                end
        end

        $display("Run complete: %0d vectors, %0d checks, %0d errors", num_vecs, checks, errors);
        if (errors == 0) begin
                $display("Simulation finished: PASS");
        end else begin
                $display("Simulation finished: FAIL");
        end
        $finish;
end

// Watchdog sized from the vector count
initial begin
        wait (loaded === 1'b1);
        #((num_vecs + 10) * 10 * 4);
        $display("Watchdog timeout, the run did not complete in time");
        $display("Simulation finished: FAIL");
        $finish;
end

endmodule

// File: tests/ucode_testdata.txt
# addr tick word | kind flag skip bus | t0 src dst op | t1 src dst op | t2 op | t3 op ofs
# | bus_read bus_write last_step (all hex, tick 0 lines expect the held word)
00 0 24003 2 0 1 3 0 0 0 0 0 0 0 0 0 1 0 1
00 1 04483 0 0 1 3 1 2 0 0 0 0 0 0 0 1 0 1
01 1 04843 0 0 1 3 2 1 0 0 0 0 0 0 0 1 0 1
02 1 20401 2 0 0 1 0 0 0 0 0 0 1 0 0 1 0 0
03 1 24000 2 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
04 1 04543 0 0 1 3 1 5 0 0 0 0 0 0 0 1 0 1
05 1 20401 2 0 0 1 0 0 0 0 0 0 1 0 0 1 0 0
06 1 24000 2 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
07 1 01443 0 0 0 3 5 1 0 0 0 0 0 0 0 1 0 1
08 1 20001 2 0 0 1 0 0 0 0 0 0 0 0 0 1 0 0
09 1 20c01 2 0 0 1 0 0 0 0 0 0 3 0 0 1 0 0
0a 1 14401 1 0 1 1 0 0 0 1 0 0 0 0 0 1 0 0
0b 1 018c3 0 0 0 3 6 3 0 0 0 0 0 0 0 1 0 1
0c 0 018c3 0 0 0 3 6 3 0 0 0 0 0 0 0 1 0 1
ff 0 018c3 0 0 0 3 6 3 0 0 0 0 0 0 0 1 0 1
0c 1 20001 2 0 0 1 0 0 0 0 0 0 0 0 0 1 0 0
0d 1 20c01 2 0 0 1 0 0 0 0 0 0 3 0 0 1 0 0
0e 1 14402 1 0 1 2 0 0 0 1 0 0 0 0 0 0 1 0
0f 1 00d83 0 0 0 3 3 6 0 0 0 0 0 0 0 1 0 1
10 1 20001 2 0 0 1 0 0 0 0 0 0 0 0 0 1 0 0
11 1 0dcc3 0 1 1 3 7 3 0 0 0 0 0 0 0 1 0 1
12 1 21001 2 0 0 1 0 0 0 0 0 0 4 0 0 1 0 0
13 1 14401 1 0 1 1 0 0 0 1 0 0 0 0 0 1 0 0
14 1 01843 0 0 0 3 6 1 0 0 0 0 0 0 0 1 0 1
15 1 21001 2 0 0 1 0 0 0 0 0 0 4 0 0 1 0 0
16 1 14402 1 0 1 2 0 0 0 1 0 0 0 0 0 0 1 0
17 1 00583 0 0 0 3 1 6 0 0 0 0 0 0 0 1 0 1
18 1 14809 1 0 1 1 0 0 0 2 0 2 0 0 0 1 0 0
19 1 01843 0 0 0 3 6 1 0 0 0 0 0 0 0 1 0 1
1a 1 21400 2 0 0 0 0 0 0 0 0 0 5 0 0 0 0 0
1b 1 14c00 1 0 1 0 0 0 0 3 0 0 0 0 0 0 0 0
1c 1 11005 1 0 0 1 0 0 0 4 0 1 0 0 0 1 0 0
1d 1 01843 0 0 0 3 6 1 0 0 0 0 0 0 0 1 0 1
1e 1 1480a 1 0 1 2 0 0 0 2 0 2 0 0 0 0 1 0
1f 1 00583 0 0 0 3 1 6 0 0 0 0 0 0 0 1 0 1
20 1 21400 2 0 0 0 0 0 0 0 0 0 5 0 0 0 0 0
21 1 14c00 1 0 1 0 0 0 0 3 0 0 0 0 0 0 0 0
22 1 11006 1 0 0 2 0 0 0 4 0 1 0 0 0 0 1 0
23 1 00583 0 0 0 3 1 6 0 0 0 0 0 0 0 1 0 1
24 1 0cc47 0 1 1 3 3 1 1 0 0 0 0 0 0 1 0 1
25 1 0c4c7 0 1 1 3 1 3 1 0 0 0 0 0 0 1 0 1
26 1 20001 2 0 0 1 0 0 0 0 0 0 0 0 0 1 0 0
27 1 0d847 0 1 1 3 6 1 1 0 0 0 0 0 0 1 0 1
28 1 20801 2 0 0 1 0 0 0 0 0 0 2 0 0 1 0 0
29 1 34100 3 0 1 0 0 0 0 0 0 0 0 0 2 0 0 0
2a 1 09944 0 1 0 0 6 5 1 0 0 0 0 0 0 0 0 0
2b 1 20003 2 0 0 3 0 0 0 0 0 0 0 0 0 1 0 1
2c 1 09947 0 1 0 3 6 5 1 0 0 0 0 0 0 1 0 1
2d 1 20001 2 0 0 1 0 0 0 0 0 0 0 0 0 1 0 0
2e 1 20c01 2 0 0 1 0 0 0 0 0 0 3 0 0 1 0 0
2f 1 14443 1 0 1 3 0 0 0 1 1 0 0 0 0 1 0 1
30 1 15443 1 0 1 3 0 0 0 5 1 0 0 0 0 1 0 1
31 1 24000 2 0 1 0 0 0 0 0 0 0 0 0 0 0 0 0
32 1 20000 2 0 0 0 0 0 0 0 0 0 0 0 0 0 0 0
33 1 12047 1 0 0 3 0 0 0 8 1 1 0 0 0 1 0 1
34 1 20001 2 0 0 1 0 0 0 0 0 0 0 0 0 1 0 0
35 1 20c01 2 0 0 1 0 0 0 0 0 0 3 0 0 1 0 0
36 1 1580e 1 0 1 2 0 0 0 6 0 3 0 0 0 0 1 0
37 1 11c82 1 0 0 2 0 0 0 7 2 0 0 0 0 0 1 0
38 1 10443 1 0 0 3 0 0 0 1 1 0 0 0 0 1 0 1
39 1 15811 1 0 1 1 0 0 0 6 0 4 0 0 0 1 0 0
3a 1 20c01 2 0 0 1 0 0 0 0 0 0 3 0 0 1 0 0
3b 1 10443 1 0 0 3 0 0 0 1 1 0 0 0 0 1 0 1
3c 1 25803 2 0 1 3 0 0 0 0 0 0 6 0 0 1 0 1
3d 1 25c03 2 0 1 3 0 0 0 0 0 0 7 0 0 1 0 1
3e 1 24003 2 0 1 3 0 0 0 0 0 0 0 0 0 1 0 1
3f 1 30403 3 0 0 3 0 0 0 0 0 0 0 1 0 1 0 1
2a 0 30403 3 0 0 3 0 0 0 0 0 0 0 1 0 1 0 1

// File: ucode/ucode_decoder.sv
`timescale 1ns/1ps

module ucode_decoder (
        input  logic                   i_CLK,
        input  logic                   arst_n,
        input  logic                   word_load,
        input  ucode_pkg::ucode_word_t ucode_word,
        output ucode_pkg::ucode_ctrl_t ctrl,
        output logic                   ctrl_valid
);

function automatic ucode_pkg::ucode_ctrl_t decode(ucode_pkg::ucode_word_t w);
        ucode_pkg::ucode_ctrl_t c;
        ucode_pkg::bus_cycle_t  bus;

        c = '0; // Unused kind groups stay at MOV, NOP or IGNORE
        bus = w.body.t0.bus;
        c.kind = w.kind;
        c.flag = w.flag;
        c.skip = w.skip;
        c.bus = bus;
        case (w.kind)
        ucode_pkg::MCTYPE0: begin
                c.t0.src = w.body.t0.src;
                c.t0.dst = w.body.t0.dst;
                c.t0.op = w.body.t0.op;
        end
        ucode_pkg::MCTYPE1: begin
                c.t1.src = w.body.t1.src;
                c.t1.dst = w.body.t1.dst;
                c.t1.op = w.body.t1.op;
        end
        ucode_pkg::MCTYPE2: begin
                c.t2_op = w.body.t2.op;
        end
        default: begin
                c.t3.op = w.body.t3.op;
                c.t3.offset = w.body.t3.offset;
        end
        endcase
        c.bus_read = (bus == ucode_pkg::RD3) || (bus == ucode_pkg::RD4);
        c.bus_write = (bus == ucode_pkg::WR3);
        c.last_step = (bus == ucode_pkg::RD4); // Opcode fetch ends the instruction
        return c;
endfunction

ucode_pkg::ucode_ctrl_t ctrl_d;

always_comb begin
        ctrl_d = decode(ucode_word);
end

always_ff @(posedge i_CLK or negedge arst_n) begin
        if (!arst_n) begin
                ctrl <= decode(ucode_pkg::NOP_WORD);
                ctrl_valid <= 1'b0;
        end else begin
                ctrl_valid <= word_load; // One pulse per load
                if (word_load) begin
                        ctrl <= ctrl_d;
                end
        end
end

endmodule

// File: ucode/ucode_rom.sv
`timescale 1ns/1ps

module ucode_rom (
        input  logic                   i_CLK,
        input  logic                   arst_n,
        input  logic                   read_tick,
        input  ucode_pkg::ucode_addr_t ucode_addr,
        output ucode_pkg::ucode_word_t ucode_word
);

always_ff @(posedge i_CLK or negedge arst_n) begin
        if (!arst_n) begin
                ucode_word <= ucode_pkg::NOP_WORD;
        end else if (read_tick) begin
                case (ucode_addr)
                // 8-bit transfers
                ucode_pkg::MOV_R1_A: ucode_word <= ucode_pkg::t0w(2'b01,
                        ucode_pkg::T0S_A, ucode_pkg::T0D_R1, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::MOV_A_R1: ucode_word <= ucode_pkg::t0w(2'b01,
                        ucode_pkg::T0S_R1, ucode_pkg::T0D_A, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::MOV_SR_A: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_SR, ucode_pkg::RD3);
                ucode_pkg::MOV_SR_A + 8'd1: ucode_word <= ucode_pkg::t2w(2'b01,
                        ucode_pkg::T2_NOP, ucode_pkg::IDLE);
                ucode_pkg::MOV_SR_A + 8'd2: ucode_word <= ucode_pkg::t0w(2'b01, ucode_pkg::T0S_A,
                        ucode_pkg::T0D_SRTMP, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::MOV_A_SR1: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_SR, ucode_pkg::RD3);
                ucode_pkg::MOV_A_SR1 + 8'd1: ucode_word <= ucode_pkg::t2w(2'b01,
                        ucode_pkg::T2_NOP, ucode_pkg::IDLE);
                ucode_pkg::MOV_A_SR1 + 8'd2: ucode_word <= ucode_pkg::t0w(2'b00,
                        ucode_pkg::T0S_SRTMP, ucode_pkg::T0D_A, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::MOV_R_MEM: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_NOP, ucode_pkg::RD3);
                ucode_pkg::MOV_R_MEM + 8'd1: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_WORD, ucode_pkg::RD3);
                ucode_pkg::MOV_R_MEM + 8'd2: ucode_word <= ucode_pkg::t1w(2'b01, // MA from AAUX
                        ucode_pkg::T1S_AAUX, ucode_pkg::T1D_MA, ucode_pkg::AEU_MOV, ucode_pkg::RD3);
                ucode_pkg::MOV_R_MEM + 8'd3: ucode_word <= ucode_pkg::t0w(2'b00,
                        ucode_pkg::T0S_MD0, ucode_pkg::T0D_R, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::MOV_MEM_R: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_NOP, ucode_pkg::RD3);
                ucode_pkg::MOV_MEM_R + 8'd1: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_WORD, ucode_pkg::RD3);
                ucode_pkg::MOV_MEM_R + 8'd2: ucode_word <= ucode_pkg::t1w(2'b01,
                        ucode_pkg::T1S_AAUX, ucode_pkg::T1D_MA, ucode_pkg::AEU_MOV, ucode_pkg::WR3);
                ucode_pkg::MOV_MEM_R + 8'd3: ucode_word <= ucode_pkg::t0w(2'b00,
                        ucode_pkg::T0S_R, ucode_pkg::T0D_MD0, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::MVI_R_IM: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_NOP, ucode_pkg::RD3);
                ucode_pkg::MVI_R_IM + 8'd1: ucode_word <= ucode_pkg::t0w(2'b11,
                        ucode_pkg::T0S_MD, ucode_pkg::T0D_R, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::LDAW: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_BYTE, ucode_pkg::RD3);
                ucode_pkg::LDAW + 8'd1: ucode_word <= ucode_pkg::t1w(2'b01, // MA from Vwa
                        ucode_pkg::T1S_AAUX, ucode_pkg::T1D_MA, ucode_pkg::AEU_MOV, ucode_pkg::RD3);
                ucode_pkg::LDAW + 8'd2: ucode_word <= ucode_pkg::t0w(2'b00,
                        ucode_pkg::T0S_MD0, ucode_pkg::T0D_A, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::STAW: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_BYTE, ucode_pkg::RD3);
                ucode_pkg::STAW + 8'd1: ucode_word <= ucode_pkg::t1w(2'b01,
                        ucode_pkg::T1S_AAUX, ucode_pkg::T1D_MA, ucode_pkg::AEU_MOV, ucode_pkg::WR3);
                ucode_pkg::STAW + 8'd2: ucode_word <= ucode_pkg::t0w(2'b00,
                        ucode_pkg::T0S_A, ucode_pkg::T0D_MD0, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::LDAX_A_RPA: ucode_word <= ucode_pkg::t1w(2'b01, ucode_pkg::T1S_RPA,
                        ucode_pkg::T1D_MA, ucode_pkg::AEU_RPA_ADJ, ucode_pkg::RD3);
                ucode_pkg::LDAX_A_RPA + 8'd1: ucode_word <= ucode_pkg::t0w(2'b00,
                        ucode_pkg::T0S_MD0, ucode_pkg::T0D_A, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::LDAX_A_RPA2: ucode_word <= ucode_pkg::t2w(2'b00, // Conditional read
                        ucode_pkg::T2_STA_IRO, ucode_pkg::IDLE);
                ucode_pkg::LDAX_A_RPA2 + 8'd1: ucode_word <= ucode_pkg::t1w(2'b01,
                        ucode_pkg::T1S_RPA2, ucode_pkg::T1D_MA, ucode_pkg::AEU_MOV, ucode_pkg::IDLE);
                ucode_pkg::LDAX_A_RPA2 + 8'd2: ucode_word <= ucode_pkg::t1w(2'b00,
                        ucode_pkg::T1S_RPA_OFFSET, ucode_pkg::T1D_MA, ucode_pkg::AEU_ADD,
                        ucode_pkg::RD3);
                ucode_pkg::LDAX_A_RPA2 + 8'd3: ucode_word <= ucode_pkg::t0w(2'b00,
                        ucode_pkg::T0S_MD0, ucode_pkg::T0D_A, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::STAX_RPA_A: ucode_word <= ucode_pkg::t1w(2'b01, ucode_pkg::T1S_RPA,
                        ucode_pkg::T1D_MA, ucode_pkg::AEU_RPA_ADJ, ucode_pkg::WR3);
                ucode_pkg::STAX_RPA_A + 8'd1: ucode_word <= ucode_pkg::t0w(2'b00,
                        ucode_pkg::T0S_A, ucode_pkg::T0D_MD0, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                ucode_pkg::STAX_RPA2_A: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_IRO, ucode_pkg::IDLE);
                ucode_pkg::STAX_RPA2_A + 8'd1: ucode_word <= ucode_pkg::t1w(2'b01,
                        ucode_pkg::T1S_RPA2, ucode_pkg::T1D_MA, ucode_pkg::AEU_MOV, ucode_pkg::IDLE);
                ucode_pkg::STAX_RPA2_A + 8'd2: ucode_word <= ucode_pkg::t1w(2'b00,
                        ucode_pkg::T1S_RPA_OFFSET, ucode_pkg::T1D_MA, ucode_pkg::AEU_ADD,
                        ucode_pkg::WR3);
                ucode_pkg::STAX_RPA2_A + 8'd3: ucode_word <= ucode_pkg::t0w(2'b00,
                        ucode_pkg::T0S_A, ucode_pkg::T0D_MD0, ucode_pkg::DEU_MOV, ucode_pkg::RD4);
                // Register and immediate ALU
                ucode_pkg::ALU_A_R: ucode_word <= ucode_pkg::t0w(2'b11,
                        ucode_pkg::T0S_R, ucode_pkg::T0D_A, ucode_pkg::DEU_COMOP, ucode_pkg::RD4);
                ucode_pkg::ALU_R_A: ucode_word <= ucode_pkg::t0w(2'b11,
                        ucode_pkg::T0S_A, ucode_pkg::T0D_R, ucode_pkg::DEU_COMOP, ucode_pkg::RD4);
                ucode_pkg::ALUI_A_IM: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_NOP, ucode_pkg::RD3);
                ucode_pkg::ALUI_A_IM + 8'd1: ucode_word <= ucode_pkg::t0w(2'b11,
                        ucode_pkg::T0S_MD0, ucode_pkg::T0D_A, ucode_pkg::DEU_COMOP, ucode_pkg::RD4);
                ucode_pkg::ALUI_SR2_IM: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_SR2, ucode_pkg::RD3);
                ucode_pkg::ALUI_SR2_IM + 8'd1: ucode_word <= ucode_pkg::t3w(2'b01, // MVI skips ALU
                        ucode_pkg::T3_BRA_ON_ALU, 3'd2, ucode_pkg::IDLE);
                ucode_pkg::ALUI_SR2_IM + 8'd2: ucode_word <= ucode_pkg::t0w(2'b10,
                        ucode_pkg::T0S_MD0, ucode_pkg::T0D_SRTMP, ucode_pkg::DEU_COMOP,
                        ucode_pkg::IDLE);
                ucode_pkg::ALUI_SR2_IM + 8'd3: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_NOP, ucode_pkg::RD4);
                ucode_pkg::ALUI_SR2_IM + 8'd4: ucode_word <= ucode_pkg::t0w(2'b10,
                        ucode_pkg::T0S_MD0, ucode_pkg::T0D_SRTMP, ucode_pkg::DEU_COMOP,
                        ucode_pkg::RD4);
                // Jumps, calls, returns
                ucode_pkg::JMP: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_NOP, ucode_pkg::RD3);
                ucode_pkg::JMP + 8'd1: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_WORD, ucode_pkg::RD3);
                ucode_pkg::JMP + 8'd2: ucode_word <= ucode_pkg::t1w(2'b01,
                        ucode_pkg::T1S_AAUX, ucode_pkg::T1D_PC, ucode_pkg::AEU_MOV, ucode_pkg::RD4);
                ucode_pkg::JB: ucode_word <= ucode_pkg::t1w(2'b01,
                        ucode_pkg::T1S_BC, ucode_pkg::T1D_PC, ucode_pkg::AEU_MOV, ucode_pkg::RD4);
                ucode_pkg::JR: ucode_word <= ucode_pkg::t2w(2'b01,
                        ucode_pkg::T2_NOP, ucode_pkg::IDLE);
                ucode_pkg::JR + 8'd1: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_NOP, ucode_pkg::IDLE);
                ucode_pkg::JR + 8'd2: ucode_word <= ucode_pkg::t1w(2'b00, // Short displacement
                        ucode_pkg::T1S_A_REL_S, ucode_pkg::T1D_PC, ucode_pkg::AEU_ADD, ucode_pkg::RD4);
                ucode_pkg::CALL: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_NOP, ucode_pkg::RD3);
                ucode_pkg::CALL + 8'd1: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_WORD, ucode_pkg::RD3);
                ucode_pkg::CALL + 8'd2: ucode_word <= ucode_pkg::t1w(2'b01,
                        ucode_pkg::T1S_SP, ucode_pkg::T1D_MA, ucode_pkg::AEU_PUSH, ucode_pkg::WR3);
                ucode_pkg::CALL + 8'd3: ucode_word <= ucode_pkg::t1w(2'b00, // Return address out
                        ucode_pkg::T1S_PC, ucode_pkg::T1D_MD, ucode_pkg::AEU_MOV, ucode_pkg::WR3);
                ucode_pkg::CALL + 8'd4: ucode_word <= ucode_pkg::t1w(2'b00,
                        ucode_pkg::T1S_AAUX, ucode_pkg::T1D_PC, ucode_pkg::AEU_MOV, ucode_pkg::RD4);
                ucode_pkg::RET_RETS: ucode_word <= ucode_pkg::t1w(2'b01,
                        ucode_pkg::T1S_SP, ucode_pkg::T1D_MA, ucode_pkg::AEU_POP, ucode_pkg::RD3);
                ucode_pkg::RET_RETS + 8'd1: ucode_word <= ucode_pkg::t2w(2'b00,
                        ucode_pkg::T2_STA_WORD, ucode_pkg::RD3);
                ucode_pkg::RET_RETS + 8'd2: ucode_word <= ucode_pkg::t1w(2'b00,
                        ucode_pkg::T1S_AAUX, ucode_pkg::T1D_PC, ucode_pkg::AEU_MOV, ucode_pkg::RD4);
                // Processor control
                ucode_pkg::EIDI: ucode_word <= ucode_pkg::t2w(2'b01,
                        ucode_pkg::T2_IRQ_MOD, ucode_pkg::RD4);
                ucode_pkg::SUSP: ucode_word <= ucode_pkg::t2w(2'b01,
                        ucode_pkg::T2_SUSP_EN, ucode_pkg::RD4);
                ucode_pkg::IRD: ucode_word <= ucode_pkg::t3w(2'b00, // Wait for opcode decode
                        ucode_pkg::T3_IRD, 3'd0, ucode_pkg::RD4);
                // NOP entry and every unmapped address
                default: ucode_word <= ucode_pkg::NOP_WORD;
                endcase
        end
end

endmodule

// File: ucode/ucode_top.sv
`timescale 1ns/1ps

module ucode_top (
        input  logic                   i_CLK,
        input  logic                   arst_n,
        input  logic                   read_tick,
        input  ucode_pkg::ucode_addr_t ucode_addr,
        output ucode_pkg::ucode_word_t ucode_word,
        output ucode_pkg::ucode_ctrl_t ctrl,
        output logic                   ctrl_valid
);

logic word_load;

// ROM word is ready one cycle after the tick
always_ff @(posedge i_CLK or negedge arst_n) begin
        if (!arst_n) begin
                word_load <= 1'b0;
        end else begin
                word_load <= read_tick;
        end
end

ucode_rom rom0 (
        .i_CLK      (i_CLK),
        .arst_n     (arst_n),
        .read_tick  (read_tick),
        .ucode_addr (ucode_addr),
        .ucode_word (ucode_word)
);

ucode_decoder dec0 (
        .i_CLK      (i_CLK),
        .arst_n     (arst_n),
        .word_load  (word_load),
        .ucode_word (ucode_word),
        .ctrl       (ctrl),
        .ctrl_valid (ctrl_valid)
);

endmodule
